/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    parameter int DATA_LEN = 32;  // Machine word width

    // Load size and kind, nonzero means a load
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB,
        LOAD_LH,
        LOAD_LW,
        LOAD_LBU,
        LOAD_LHU
    } load_type_e;

    // Store size, nonzero means a store
    typedef enum logic [1:0] {
        STORE_NONE = 2'd0,
        STORE_SB,
        STORE_SH,
        STORE_SW
    } store_type_e;

    // One execute-stage result
    typedef struct packed {
        logic                wd;
        logic [4:0]          wreg;
        logic [DATA_LEN-1:0] alu_result;  // Also the memory address
        logic [DATA_LEN-1:0] store_data;
        load_type_e          load_type;
        store_type_e         store_type;
        logic [DATA_LEN-1:0] csr_wdata;
    } ex_req_t;

endpackage

`default_nettype wire

/* logic/wb_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface wb_if;
    import lsu_pkg::*;

    logic [DATA_LEN-1:0] adr;  // Byte address
    logic [DATA_LEN-1:0] dat_w;
    logic [DATA_LEN-1:0] dat_r;
    logic [3:0]          sel;
    logic                we;
    logic                cyc;
    logic                stb;
    logic                ack;

    modport master (
        output adr, dat_w, sel, we, cyc, stb,
        input  dat_r, ack
    );

    modport slave (
        input  adr, dat_w, sel, we, cyc, stb,
        output dat_r, ack
    );

endinterface

`default_nettype wire

/* logic/lane_align.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_align (
    input  wire [lsu_pkg::DATA_LEN-1:0]  addr_i,
    input  wire [lsu_pkg::DATA_LEN-1:0]  store_data_i,
    input  wire lsu_pkg::store_type_e    store_type_i,
    input  wire lsu_pkg::load_type_e     load_type_i,
    input  wire [lsu_pkg::DATA_LEN-1:0]  bus_rdata_i,
    output logic [lsu_pkg::DATA_LEN-1:0] bus_wdata_o,
    output logic [3:0]                   bus_sel_o,
    output logic [lsu_pkg::DATA_LEN-1:0] load_data_o
);
    import lsu_pkg::*;

    logic [1:0]  offset;
    logic [3:0]  byte_sel;
    logic [3:0]  half_sel;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    assign offset   = addr_i[1:0];  // Upper bits pick the word only
    assign byte_sel = 4'b0001 << offset;
    assign half_sel = offset[1] ? 4'b1100 : 4'b0011;
    assign rd_byte  = bus_rdata_i[8*offset +: 8];
    assign rd_half  = offset[1] ? bus_rdata_i[31:16] : bus_rdata_i[15:0];

    // Stores replicate the data so every lane carries it
    always_comb begin
        bus_wdata_o = store_data_i;
        bus_sel_o   = 4'h0;
        case (store_type_i)
            STORE_SB: begin
                bus_wdata_o = {4{store_data_i[7:0]}};
                bus_sel_o   = byte_sel;
            end
            STORE_SH: begin
                bus_wdata_o = {2{store_data_i[15:0]}};
                bus_sel_o   = half_sel;
            end
            STORE_SW: bus_sel_o = 4'hf;
            default: begin
                case (load_type_i)  // Reads select the lanes the load uses
                    LOAD_LB, LOAD_LBU: bus_sel_o = byte_sel;
                    LOAD_LH, LOAD_LHU: bus_sel_o = half_sel;
                    LOAD_LW:           bus_sel_o = 4'hf;
                    default:           bus_sel_o = 4'h0;
                endcase
            end
        endcase
    end

    always_comb begin
        case (load_type_i)
            LOAD_LB:  load_data_o = {{(DATA_LEN-8){rd_byte[7]}}, rd_byte};
            LOAD_LBU: load_data_o = {{(DATA_LEN-8){1'b0}}, rd_byte};
            LOAD_LH:  load_data_o = {{(DATA_LEN-16){rd_half[15]}}, rd_half};
            LOAD_LHU: load_data_o = {{(DATA_LEN-16){1'b0}}, rd_half};
            LOAD_LW:  load_data_o = bus_rdata_i;
            default:  load_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          ex_valid_i,
    input  wire lsu_pkg::ex_req_t        ex_req_i,
    output logic                         wb_ready_o,
    wb_if.master                         bus,
    output logic                         finish_o,
    output logic                         wd_o,
    output logic [4:0]                   wreg_o,
    output logic [lsu_pkg::DATA_LEN-1:0] wdata_o,
    output logic [lsu_pkg::DATA_LEN-1:0] csr_wdata_o
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } state_e;

    state_e              state_q;
    ex_req_t             req_q;
    logic                cyc_q;
    logic                is_load;
    logic                is_store;
    logic                accept;
    logic                complete;
    logic [DATA_LEN-1:0] load_data;

    assign is_load    = req_q.load_type != LOAD_NONE;
    assign is_store   = req_q.store_type != STORE_NONE;
    assign wb_ready_o = state_q == IDLE;
    assign accept     = ex_valid_i && wb_ready_o;
    assign finish_o   = state_q == DONE;  // One cycle, DONE always returns to IDLE

    // Non-memory requests complete in their first BUS cycle
    assign complete = (state_q == BUS) &&
                      (!(is_load || is_store) || (cyc_q && bus.ack));

    // Bus fields come from the latched request, stable for the whole cycle
    assign bus.adr = req_q.alu_result;
    assign bus.we  = cyc_q && is_store;
    assign bus.cyc = cyc_q;
    assign bus.stb = cyc_q;

    lane_align u_lane_align (
        .addr_i       (req_q.alu_result),
        .store_data_i (req_q.store_data),
        .store_type_i (req_q.store_type),
        .load_type_i  (req_q.load_type),
        .bus_rdata_i  (bus.dat_r),
        .bus_wdata_o  (bus.dat_w),
        .bus_sel_o    (bus.sel),
        .load_data_o  (load_data)
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= ex_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            cyc_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= BUS;
                    end
                end
                BUS: begin
                    if (complete) begin
                        state_q <= DONE;
                        cyc_q   <= 1'b0;  // Drop cyc in the cycle after ack
                    end else if (is_load || is_store) begin
                        cyc_q <= 1'b1;
                    end
                end
                DONE: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Writeback fields hold until the next completion
    always_ff @(posedge clk) begin
        if (rst) begin
            wd_o        <= 1'b0;
            wreg_o      <= 5'd0;
            wdata_o     <= '0;
            csr_wdata_o <= '0;
        end else if (complete) begin
            wd_o        <= req_q.wd;
            wreg_o      <= req_q.wreg;
            csr_wdata_o <= req_q.csr_wdata;
            wdata_o     <= is_load ? load_data : req_q.alu_result;  // dat_r valid with ack
        end
    end

endmodule

`default_nettype wire

/* logic/data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int MEM_WORDS = 256
) (
    input  wire clk,
    input  wire rst,
    wb_if.slave bus
);
    import lsu_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic [DATA_LEN-1:0] mem [MEM_WORDS];
    logic [DATA_LEN-1:0] rdata_q;
    logic [ADDR_W-1:0]   word_idx;
    logic                ack_q;
    logic                req;

    assign word_idx  = bus.adr[ADDR_W+1:2];  // Upper address bits wrap
    assign req       = bus.cyc && bus.stb && !ack_q;
    assign bus.ack   = ack_q;
    assign bus.dat_r = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (req && bus.we) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.sel[b]) begin
                    mem[word_idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;  // Single-cycle ack
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdata_q <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         ex_valid_i,
    input  wire                         wd_i,
    input  wire [4:0]                   wreg_i,
    input  wire [lsu_pkg::DATA_LEN-1:0] alu_result_i,
    input  wire [lsu_pkg::DATA_LEN-1:0] store_data_i,
    input  wire [2:0]                   load_type_i,
    input  wire [1:0]                   store_type_i,
    input  wire [lsu_pkg::DATA_LEN-1:0] csr_wdata_i,
    output wire                         wb_ready_o,
    output wire                         finish_o,
    output wire                         wd_o,
    output wire [4:0]                   wreg_o,
    output wire [lsu_pkg::DATA_LEN-1:0] wdata_o,
    output wire [lsu_pkg::DATA_LEN-1:0] csr_wdata_o
);
    import lsu_pkg::*;

    ex_req_t ex_req;

    wb_if bus ();

    assign ex_req = '{
        wd:         wd_i,
        wreg:       wreg_i,
        alu_result: alu_result_i,
        store_data: store_data_i,
        load_type:  load_type_e'(load_type_i),
        store_type: store_type_e'(store_type_i),
        csr_wdata:  csr_wdata_i
    };

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst         (rst),
        .ex_valid_i  (ex_valid_i),
        .ex_req_i    (ex_req),
        .wb_ready_o  (wb_ready_o),
        .bus         (bus),
        .finish_o    (finish_o),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o),
        .csr_wdata_o (csr_wdata_o)
    );

    data_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_ram (
        .clk (clk),
        .rst (rst),
        .bus (bus)
    );

endmodule

`default_nettype wire

/* sim/tb_lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int NUM_OPS    = 479;  // 4 plain + 72 store/load + 3 held + 400 random
    localparam int TIMEOUT_NS = NUM_OPS * 10 * 100 + 16 * 100;

    logic        clk;
    logic        rst;
    logic        ex_valid_i;
    logic        wd_i;
    logic [4:0]  wreg_i;
    logic [31:0] alu_result_i;
    logic [31:0] store_data_i;
    logic [2:0]  load_type_i;
    logic [1:0]  store_type_i;
    logic [31:0] csr_wdata_i;
    wire         wb_ready_o;
    wire         finish_o;
    wire         wd_o;
    wire  [4:0]  wreg_o;
    wire  [31:0] wdata_o;
    wire  [31:0] csr_wdata_o;

    integer      seed = 84635;
    int          accept_cnt = 0;
    int          finish_cnt = 0;
    logic [7:0]  ref_mem [0:1023];  // Byte-wise model of the 1 KB RAM

    lsu_top #(
        .MEM_WORDS (256)
    ) u_lsu_top (
        .clk          (clk),
        .rst          (rst),
        .ex_valid_i   (ex_valid_i),
        .wd_i         (wd_i),
        .wreg_i       (wreg_i),
        .alu_result_i (alu_result_i),
        .store_data_i (store_data_i),
        .load_type_i  (load_type_i),
        .store_type_i (store_type_i),
        .csr_wdata_i  (csr_wdata_i),
        .wb_ready_o   (wb_ready_o),
        .finish_o     (finish_o),
        .wd_o         (wd_o),
        .wreg_o       (wreg_o),
        .wdata_o      (wdata_o),
        .csr_wdata_o  (csr_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst && finish_o) finish_cnt++;  // High for one falling edge per pulse
    end

    // Valid and ready both high at a rising edge is one accepted request
    always @(posedge clk) begin
        if (!rst && ex_valid_i && wb_ready_o) accept_cnt++;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: the run did not finish before the watchdog expired");
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            $display("Test FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // Halfwords use address bit 1 only, words ignore bits 1:0
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input logic [2:0] ltype);
        logic [9:0]  a;
        logic [9:0]  half;
        logic [9:0]  base;
        logic [7:0]  b;
        logic [15:0] h;
        a    = addr[9:0];
        half = {a[9:1], 1'b0};
        base = {a[9:2], 2'b00};
        b    = ref_mem[a];
        h    = {ref_mem[half+1], ref_mem[half]};
        case (ltype)
            LOAD_LB:  return {{24{b[7]}}, b};
            LOAD_LBU: return {24'd0, b};
            LOAD_LH:  return {{16{h[15]}}, h};
            LOAD_LHU: return {16'd0, h};
            LOAD_LW:  return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
            default:  return 32'd0;
        endcase
    endfunction

    task automatic update_model(input logic [31:0] addr, input logic [31:0] data,
                                input logic [1:0] stype);
        logic [9:0] a;
        a = addr[9:0];
        case (stype)
            STORE_SB: ref_mem[a] = data[7:0];
            STORE_SH: begin
                ref_mem[{a[9:1], 1'b0}] = data[7:0];
                ref_mem[{a[9:1], 1'b1}] = data[15:8];
            end
            STORE_SW: begin
                for (int i = 0; i < 4; i++) ref_mem[{a[9:2], 2'b00} + i] = data[8*i +: 8];
            end
            default: ;
        endcase
    endtask

    // Called just after a falling edge, returns just after a falling edge
    task automatic run_request(input logic [2:0] ltype, input logic [1:0] stype,
                               input logic [31:0] addr, input bit hold);
        logic [31:0] rnd;
        logic [31:0] sdata;
        logic [31:0] csr;
        logic [31:0] exp_wdata;
        logic        wd;
        logic [4:0]  wreg;
        int          lat;
        rnd   = $random(seed);
        wd    = rnd[0];
        wreg  = rnd[5:1];
        sdata = $random(seed);
        csr   = $random(seed);
        exp_wdata = (ltype != LOAD_NONE) ? expected_load(addr, ltype) : addr;
        ex_valid_i   = 1'b1;
        wd_i         = wd;
        wreg_i       = wreg;
        alu_result_i = addr;
        store_data_i = sdata;
        load_type_i  = ltype;
        store_type_i = stype;
        csr_wdata_i  = csr;
        while (!wb_ready_o) @(negedge clk);
        @(posedge clk);  // Accept edge
        @(negedge clk);
        if (!hold) begin
            ex_valid_i   = 1'b0;
            alu_result_i = $random(seed);  // Stage must work from its latched copy
            store_data_i = $random(seed);
            csr_wdata_i  = $random(seed);
        end
        lat = 0;
        while (!finish_o) begin
            check_value(wb_ready_o, 1'b0, "ready high while a request is outstanding");
            @(negedge clk);
            lat++;
        end
        check_value(wb_ready_o, 1'b0, "ready high during finish");
        ex_valid_i = 1'b0;
        check_value(lat, (ltype != LOAD_NONE || stype != STORE_NONE) ? 3 : 1, "finish latency");
        check_value(wd_o, wd, "wd_o");
        check_value(wreg_o, wreg, "wreg_o");
        check_value(wdata_o, exp_wdata, "wdata_o");
        check_value(csr_wdata_o, csr, "csr_wdata_o");
        if (stype != STORE_NONE) update_model(addr, sdata, stype);
        @(negedge clk);
        check_value(finish_o, 1'b0, "finish_o longer than one cycle");
        check_value(wb_ready_o, 1'b1, "ready low after finish");
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [2:0]  lt;
        logic [1:0]  st;
        rst          = 1'b1;
        ex_valid_i   = 1'b0;
        wd_i         = 1'b0;
        wreg_i       = 5'd0;
        alu_result_i = 32'd0;
        store_data_i = 32'd0;
        load_type_i  = 3'd0;
        store_type_i = 2'd0;
        csr_wdata_i  = 32'd0;
        for (int i = 0; i < 1024; i++) ref_mem[i] = 8'h00;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        check_value(finish_o, 1'b0, "finish_o after reset");
        check_value(wb_ready_o, 1'b1, "wb_ready_o after reset");
        check_value(wd_o, 1'b0, "wd_o after reset");
        check_value(wreg_o, 5'd0, "wreg_o after reset");
        check_value(wdata_o, 32'd0, "wdata_o after reset");
        check_value(csr_wdata_o, 32'd0, "csr_wdata_o after reset");

        repeat (4) run_request(LOAD_NONE, STORE_NONE, $random(seed), 1'b0);

        // Each store size, then loads from the same and neighboring bytes
        for (int r = 0; r < 12; r++) begin
            addr = $random(seed) & 32'h3ff;
            st   = 2'(r % 3 + 1);
            run_request(LOAD_NONE, st, addr, 1'b0);
            run_request(LOAD_LW, STORE_NONE, addr, 1'b0);
            run_request(LOAD_LH, STORE_NONE, addr, 1'b0);
            run_request(LOAD_LHU, STORE_NONE, addr ^ 32'h2, 1'b0);
            run_request(LOAD_LB, STORE_NONE, addr, 1'b0);
            run_request(LOAD_LBU, STORE_NONE, (addr + 1) & 32'h3ff, 1'b0);
        end

        // Valid held high through the whole request
        run_request(LOAD_NONE, STORE_NONE, $random(seed), 1'b1);
        run_request(LOAD_NONE, STORE_SW, 32'h0000_0104, 1'b1);
        run_request(LOAD_LB, STORE_NONE, 32'h0000_0107, 1'b1);

        for (int n = 0; n < 400; n++) begin
            rnd  = $random(seed);
            addr = $random(seed);
            lt   = LOAD_NONE;
            st   = STORE_NONE;
            case (rnd[31:30])
                2'd0: ;                                        // Plain ALU result
                2'd1: st = (rnd[29:28] == 2'd0) ? STORE_SW : rnd[29:28];
                default: lt = rnd[27:25] % 3'd5 + 3'd1;
            endcase
            if (lt != LOAD_NONE || st != STORE_NONE) addr = addr & 32'h3ff;
            run_request(lt, st, addr, rnd[24]);
            repeat (rnd[23:22]) @(negedge clk);  // Idle gap
        end

        check_value(accept_cnt, NUM_OPS, "accepted request count");
        check_value(finish_cnt, NUM_OPS, "finish pulse count");
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_wb.f */
logic/lsu_pkg.sv
logic/wb_if.sv
logic/lane_align.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/lsu_top.sv
sim/tb_lsu_top.sv

/* Bender.yml */
package:
  name: lsu_wb

sources:
  - logic/lsu_pkg.sv
  - logic/wb_if.sv
  - logic/lane_align.sv
  - logic/mem_stage.sv
  - logic/data_ram.sv
  - logic/lsu_top.sv
  - target: simulation
    files:
      - sim/tb_lsu_top.sv
